// File: list.f
led_status_pkg.sv
led_frame_timer.sv
led_cfg_regs.sv
led_blinker.sv
led_status_top.sv
led_status_assert.sv
tb_led_status.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_led_status
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_led_status.sv
//------------------------------------------------------------
// directed testbench for the LED status indicator
// host tasks, frame measurement, typed compare tasks, timeout
//------------------------------------------------------------
`timescale 1ns/100ps

module tb_led_status;
   import led_status_pkg::*;

   localparam int NCH = 4;
   localparam int PERIOD = 64;
   localparam int BLINK_ON = 2;
   localparam int BLINK_OFF = 3;
   // blinks that fit in one frame
   localparam int MAX_BLINKS = (PERIOD - 1) / (BLINK_ON + BLINK_OFF);
   localparam led_amount_t MAX_CNT = led_amount_t'(MAX_BLINKS);
   // tick, latch cycle, then the first pulse
   localparam int FIRST_RISE = 2;
   // tests use about 25 frames
   localparam int TIMEOUT_CYC = 40 * PERIOD + 256;

   logic ClkRs_ix;
   logic rst_n_i;
   logic wr_stb_i;
   led_wr_t wr_i;
   logic rd_stb_i;
   led_chan_t rd_chan_i;
   led_rd_t rd_o;
   logic rd_valid_o;
   logic [NCH-1:0] led_o;
   logic frame_o;

   // one measured frame, per channel
   int rises[NCH];
   int first_rise[NCH];
   int n_high[NCH];
   int high_len[NCH][16];
   int low_len[NCH][16];
   logic start_lvl[NCH];
   logic all_high[NCH];
   int frame_len;

   logic [31:0] rng_q = 32'h1042_25b8;
   int cyc_cnt = 0;

   led_status_top #(
      .g_num_chan    (NCH),
      .g_total_period(PERIOD),
      .g_blink_on    (BLINK_ON),
      .g_blink_off   (BLINK_OFF)
   ) DUT (
      .ClkRs_ix  (ClkRs_ix),
      .rst_n_i   (rst_n_i),
      .wr_stb_i  (wr_stb_i),
      .wr_i      (wr_i),
      .rd_stb_i  (rd_stb_i),
      .rd_chan_i (rd_chan_i),
      .rd_o      (rd_o),
      .rd_valid_o(rd_valid_o),
      .led_o     (led_o),
      .frame_o   (frame_o)
   );

   initial begin
      ClkRs_ix = 1'b0;
      forever #5 ClkRs_ix = ~ClkRs_ix;
   end

   //------------------------------------------------------------
   // failure handling and compare tasks
   //------------------------------------------------------------

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
         stop_run("bit mismatch");
      end
   endtask

   task automatic check_amount(input string name, input led_amount_t got,
                               input led_amount_t exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
         stop_run("count mismatch");
      end
   endtask

   task automatic check_rd(input string name, input led_rd_t got, input led_rd_t exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s is amount %0d force %b, expected amount %0d force %b",
                  $time, name, got.amount, got.force_on, exp.amount, exp.force_on);
         stop_run("read-back mismatch");
      end
   endtask

   // global watchdog
   always @(posedge ClkRs_ix) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt > TIMEOUT_CYC)
         stop_run($sformatf("timeout after %0d cycles, tests did not complete", cyc_cnt));
   end

   //------------------------------------------------------------
   // stimulus helpers
   //------------------------------------------------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // 0 to 20, some above the clamp limit
   function automatic led_amount_t rand_count();
      rng_q = xorshift32(rng_q);
      return led_amount_t'(rng_q % 32'd21);
   endfunction

   function automatic led_amount_t clamp_count(input led_amount_t n);
      return (n > MAX_CNT) ? MAX_CNT : n;
   endfunction

   task automatic write_chan(input led_chan_t ch, input led_amount_t amount,
                             input logic force_on);
      @(posedge ClkRs_ix);
      #1;
      wr_i.chan = ch;
      wr_i.amount = amount;
      wr_i.force_on = force_on;
      wr_stb_i = 1'b1;
      @(posedge ClkRs_ix);
      #1;
      wr_stb_i = 1'b0;
   endtask

   // data and valid one cycle after the strobe
   task automatic read_chan(input led_chan_t ch, output led_rd_t rd);
      @(posedge ClkRs_ix);
      #1;
      rd_chan_i = ch;
      rd_stb_i = 1'b1;
      @(posedge ClkRs_ix);
      #1;
      rd_stb_i = 1'b0;
      check_bit("rd_valid_o", rd_valid_o, 1'b1);
      rd = rd_o;
   endtask

   // outputs sampled on the falling edge
   task automatic wait_frame();
      do @(negedge ClkRs_ix); while (!frame_o);
   endtask

   // index 0 is the frame_o sample, stops at the next frame_o
   task automatic measure_frame();
      int run[NCH];
      logic prev[NCH];
      logic cur;
      int cyc;
      wait_frame();
      for (int ch = 0; ch < NCH; ch++) begin
         rises[ch] = 0;
         first_rise[ch] = -1;
         n_high[ch] = 0;
         start_lvl[ch] = led_o[ch];
         all_high[ch] = led_o[ch];
         prev[ch] = led_o[ch];
         run[ch] = 1;
      end
      cyc = 0;
      forever begin
         @(negedge ClkRs_ix);
         cyc++;
         if (frame_o)
            break;
         for (int ch = 0; ch < NCH; ch++) begin
            cur = led_o[ch];
            all_high[ch] = all_high[ch] & cur;
            if (cur == prev[ch]) begin
               run[ch]++;
            end else begin
               if (prev[ch]) begin
                  // falling edge closes a high run
                  if (n_high[ch] < 16)
                     high_len[ch][n_high[ch]] = run[ch];
                  n_high[ch]++;
               end else begin
                  // gap counted only between two pulses
                  if (rises[ch] > 0 && rises[ch] <= 16)
                     low_len[ch][rises[ch]-1] = run[ch];
                  if (first_rise[ch] < 0)
                     first_rise[ch] = cyc;
                  rises[ch]++;
               end
               run[ch] = 1;
            end
            prev[ch] = cur;
         end
      end
      frame_len = cyc;
   endtask

   task automatic check_pattern(input int ch, input led_amount_t exp);
      check_bit($sformatf("led_o[%0d] at frame start", ch), start_lvl[ch], 1'b0);
      check_amount($sformatf("led_o[%0d] rising edges", ch), led_amount_t'(rises[ch]), exp);
      check_amount($sformatf("led_o[%0d] high pulses", ch), led_amount_t'(n_high[ch]), exp);
      if (exp != '0) begin
         check_amount($sformatf("led_o[%0d] first rise", ch), led_amount_t'(first_rise[ch]),
                      led_amount_t'(FIRST_RISE));
         for (int i = 0; i < n_high[ch]; i++)
            check_amount($sformatf("led_o[%0d] high run %0d", ch, i),
                         led_amount_t'(high_len[ch][i]), led_amount_t'(BLINK_ON));
         for (int i = 0; i < rises[ch] - 1; i++)
            check_amount($sformatf("led_o[%0d] low gap %0d", ch, i),
                         led_amount_t'(low_len[ch][i]), led_amount_t'(BLINK_OFF));
      end
   endtask

   //------------------------------------------------------------
   // directed tests
   //------------------------------------------------------------

   task automatic test_reset();
      led_rd_t rd;
      for (int ch = 0; ch < NCH; ch++) begin
         read_chan(led_chan_t'(ch), rd);
         check_rd($sformatf("rd_o ch%0d after reset", ch), rd, '0);
      end
      // dark until the first tick
      @(negedge ClkRs_ix);
      while (!frame_o) begin
         check_bit("led_o before first frame", |led_o, 1'b0);
         @(negedge ClkRs_ix);
      end
      measure_frame();
      check_amount("frame_o period", led_amount_t'(frame_len), led_amount_t'(PERIOD));
      for (int ch = 0; ch < NCH; ch++)
         check_pattern(ch, '0);
   endtask

   // distinct counts, full pulse shape
   task automatic test_blink();
      led_amount_t cnt[NCH] = '{8'd3, 8'd7, 8'd12, 8'd1};
      wait_frame();
      for (int ch = 0; ch < NCH; ch++)
         write_chan(led_chan_t'(ch), cnt[ch], 1'b0);
      measure_frame();
      for (int ch = 0; ch < NCH; ch++)
         check_pattern(ch, cnt[ch]);
   endtask

   task automatic test_clamp();
      led_amount_t val;
      led_rd_t exp[NCH];
      led_rd_t rd;
      repeat (3) begin
         wait_frame();
         for (int ch = 0; ch < NCH; ch++) begin
            val = rand_count();
            exp[ch].amount = clamp_count(val);
            exp[ch].force_on = 1'b0;
            write_chan(led_chan_t'(ch), val, 1'b0);
         end
         for (int ch = 0; ch < NCH; ch++) begin
            read_chan(led_chan_t'(ch), rd);
            check_rd($sformatf("rd_o ch%0d clamped", ch), rd, exp[ch]);
         end
         measure_frame();
         for (int ch = 0; ch < NCH; ch++)
            check_pattern(ch, exp[ch].amount);
      end
      // channels past the last one hit nothing
      wait_frame();
      write_chan(3'd5, 8'd9, 1'b1);
      write_chan(3'd7, 8'd1, 1'b1);
      for (int ch = 0; ch < NCH; ch++) begin
         read_chan(led_chan_t'(ch), rd);
         check_rd($sformatf("rd_o ch%0d after stray write", ch), rd, exp[ch]);
      end
      measure_frame();
      for (int ch = 0; ch < NCH; ch++)
         check_pattern(ch, exp[ch].amount);
   endtask

   task automatic test_force();
      led_rd_t rd;
      led_rd_t exp;
      wait_frame();
      write_chan(3'd1, 8'd4, 1'b1);
      // stored force bit comes back on the read port
      exp.amount = 8'd4;
      exp.force_on = 1'b1;
      read_chan(3'd1, rd);
      check_rd("rd_o ch1 forced", rd, exp);
      measure_frame();
      check_bit("led_o[1] forced for whole frame", all_high[1], 1'b1);
      // writes land after the latch, so they show one frame later
      write_chan(3'd1, 8'd4, 1'b0);
      measure_frame();
      check_pattern(1, 8'd4);
      write_chan(3'd1, 8'd0, 1'b0);
      measure_frame();
      check_pattern(1, 8'd0);
   endtask

   initial begin
      rst_n_i = 1'b0;
      wr_stb_i = 1'b0;
      wr_i = '0;
      rd_stb_i = 1'b0;
      rd_chan_i = '0;
      repeat (16) @(posedge ClkRs_ix);
      #1;
      rst_n_i = 1'b1;
      test_reset();
      test_blink();
      test_clamp();
      test_force();
      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: led_status_assert.sv
//------------------------------------------------------------
// concurrent checks on the LED status top level
//------------------------------------------------------------
`timescale 1ns/100ps

module led_status_assert #(
   parameter int g_num_chan     = 4,
   parameter int g_total_period = 64,
   parameter int g_blink_on     = 2,
   parameter int g_blink_off    = 3
) (
   input logic                  ClkRs_ix,
   input logic                  rst_n_i,
   input logic                  rd_stb_i,
   input logic                  rd_valid_i,
   input logic [g_num_chan-1:0] led_i,
   input logic                  frame_i
);
   import led_status_pkg::*;

   // channel index must reach every channel
   a_num_chan: assert property (@(posedge ClkRs_ix)
      g_num_chan >= 1 && g_num_chan <= (1 << CHAN_W))
      else $error("g_num_chan out of range");

   // at least one full blink per frame
   a_blink_fit: assert property (@(posedge ClkRs_ix)
      g_blink_on >= 1 && g_blink_off >= 1 &&
      (g_total_period - 1) / (g_blink_on + g_blink_off) >= 1)
      else $error("blink timing does not fit the frame");

   a_reset_dark: assert property (@(posedge ClkRs_ix)
      !rst_n_i |-> (led_i == '0 && !frame_i))
      else $error("led or frame active in reset");

   // tick is a single-cycle pulse
   a_frame_pulse: assert property (@(posedge ClkRs_ix) disable iff (!rst_n_i)
      frame_i |=> !frame_i)
      else $error("frame pulse longer than one cycle");

   a_rd_valid: assert property (@(posedge ClkRs_ix) disable iff (!rst_n_i)
      rd_valid_i == $past(rd_stb_i))
      else $error("read valid does not follow the read strobe");

endmodule

bind led_status_top led_status_assert #(
   .g_num_chan    (g_num_chan),
   .g_total_period(g_total_period),
   .g_blink_on    (g_blink_on),
   .g_blink_off   (g_blink_off)
) u_assert (
   .ClkRs_ix  (ClkRs_ix),
   .rst_n_i   (rst_n_i),
   .rd_stb_i  (rd_stb_i),
   .rd_valid_i(rd_valid_o),
   .led_i     (led_o),
   .frame_i   (frame_o)
);

// File: led_status_top.sv
//------------------------------------------------------------
// LED status indicator top level
// frame timer, config registers, one blinker per channel
//------------------------------------------------------------
`timescale 1ns/100ps

module led_status_top #(
   parameter int g_num_chan     = 4,
   parameter int g_total_period = 64,
   parameter int g_blink_on     = 2,
   parameter int g_blink_off    = 3
) (
   input  logic                      ClkRs_ix,
   input  logic                      rst_n_i,
   input  logic                      wr_stb_i,
   input  led_status_pkg::led_wr_t   wr_i,
   input  logic                      rd_stb_i,
   input  led_status_pkg::led_chan_t rd_chan_i,
   output led_status_pkg::led_rd_t   rd_o,
   output logic                      rd_valid_o,
   output logic [g_num_chan-1:0]     led_o,
   output logic                      frame_o
);
   import led_status_pkg::*;

   logic frame_tick;
   led_amount_t [g_num_chan-1:0] amount_b;
   logic [g_num_chan-1:0] force_b;

   led_frame_timer #(
      .g_total_period(g_total_period)
   ) u_frame_timer (
      .ClkRs_ix    (ClkRs_ix),
      .rst_n_i     (rst_n_i),
      .frame_tick_o(frame_tick)
   );

   led_cfg_regs #(
      .g_num_chan    (g_num_chan),
      .g_total_period(g_total_period),
      .g_blink_on    (g_blink_on),
      .g_blink_off   (g_blink_off)
   ) u_cfg_regs (
      .ClkRs_ix  (ClkRs_ix),
      .rst_n_i   (rst_n_i),
      .wr_stb_i  (wr_stb_i),
      .wr_i      (wr_i),
      .rd_stb_i  (rd_stb_i),
      .rd_chan_i (rd_chan_i),
      .rd_o      (rd_o),
      .rd_valid_o(rd_valid_o),
      .amount_o  (amount_b),
      .force_o   (force_b)
   );

   // one sequencer per LED, all on the shared frame tick
   for (genvar ch = 0; ch < g_num_chan; ch++) begin : g_chan
      led_blinker #(
         .g_blink_on (g_blink_on),
         .g_blink_off(g_blink_off)
      ) u_blinker (
         .ClkRs_ix    (ClkRs_ix),
         .rst_n_i     (rst_n_i),
         .frame_tick_i(frame_tick),
         .amount_i    (amount_b[ch]),
         .force_i     (force_b[ch]),
         .led_o       (led_o[ch])
      );
   end

   // host sees the same tick the blinkers use
   assign frame_o = frame_tick;

endmodule

// File: led_blinker.sv
//------------------------------------------------------------
// per-channel blink sequencer FSM with force override
//------------------------------------------------------------
`timescale 1ns/100ps

module led_blinker #(
   parameter int g_blink_on  = 2,
   parameter int g_blink_off = 3
) (
   input  logic                        ClkRs_ix,
   input  logic                        rst_n_i,
   input  logic                        frame_tick_i,
   input  led_status_pkg::led_amount_t amount_i,
   input  logic                        force_i,
   output logic                        led_o
);
   import led_status_pkg::*;

   // on counter runs from on - 1 down to zero
   localparam int ON_W = (g_blink_on > 1) ? $clog2(g_blink_on) : 1;
   // off phase is one cycle short, COUNTDOWN supplies the last low cycle
   localparam int OFF_W = (g_blink_off > 1) ? $clog2(g_blink_off) : 1;
   localparam logic [ON_W-1:0] ON_LOAD = ON_W'(g_blink_on - 1);
   localparam logic [OFF_W-1:0] OFF_LOAD =
      OFF_W'((g_blink_off > 1) ? g_blink_off - 2 : 0);

   blink_state_e state_q;
   // pulses still to go in this frame
   led_amount_t remain_q;
   logic [ON_W-1:0] on_cnt_q;
   logic [OFF_W-1:0] off_cnt_q;

   //------------------------------------------------------------
   // sequencer
   //------------------------------------------------------------

   always_ff @(posedge ClkRs_ix or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         remain_q <= '0;
         on_cnt_q <= '0;
         off_cnt_q <= '0;
      end else if (frame_tick_i) begin
         // tick wins over any running sequence
         remain_q <= amount_i;
         // zero count stays dark
         if (amount_i != '0)
            state_q <= COUNTDOWN;
         else
            state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: begin
               // dark until the next tick
               state_q <= IDLE;
            end

            COUNTDOWN: begin
               if (remain_q == '0) begin
                  state_q <= IDLE;
               end else begin
                  remain_q <= remain_q - 1'b1;
                  on_cnt_q <= ON_LOAD;
                  state_q <= LED_ON;
               end
            end

            LED_ON: begin
               if (on_cnt_q != '0) begin
                  on_cnt_q <= on_cnt_q - 1'b1;
               end else if (g_blink_off > 1) begin
                  off_cnt_q <= OFF_LOAD;
                  state_q <= LED_OFF;
               end else begin
                  // single off cycle is COUNTDOWN alone
                  state_q <= COUNTDOWN;
               end
            end

            LED_OFF: begin
               if (off_cnt_q != '0)
                  off_cnt_q <= off_cnt_q - 1'b1;
               else
                  state_q <= COUNTDOWN;
            end

            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // led straight from the state register, force on top
   assign led_o = force_i | (state_q == LED_ON);

endmodule

// File: led_cfg_regs.sv
//------------------------------------------------------------
// per-channel blink count and force registers
// write clamping and registered read-back
//------------------------------------------------------------
`timescale 1ns/100ps

module led_cfg_regs #(
   parameter int g_num_chan     = 4,
   parameter int g_total_period = 64,
   parameter int g_blink_on     = 2,
   parameter int g_blink_off    = 3
) (
   input  logic                                         ClkRs_ix,
   input  logic                                         rst_n_i,
   input  logic                                         wr_stb_i,
   input  led_status_pkg::led_wr_t                      wr_i,
   input  logic                                         rd_stb_i,
   input  led_status_pkg::led_chan_t                    rd_chan_i,
   output led_status_pkg::led_rd_t                      rd_o,
   output logic                                         rd_valid_o,
   output led_status_pkg::led_amount_t [g_num_chan-1:0] amount_o,
   output logic [g_num_chan-1:0]                        force_o
);
   import led_status_pkg::*;

   // blinks that still finish inside one frame
   localparam int MAX_BLINKS = (g_total_period - 1) / (g_blink_on + g_blink_off);
   localparam int AMOUNT_TOP = 2**AMOUNT_W - 1;
   localparam led_amount_t MAX_AMOUNT =
      led_amount_t'((MAX_BLINKS < AMOUNT_TOP) ? MAX_BLINKS : AMOUNT_TOP);

   led_amount_t wr_amount;
   led_rd_t rd_data;

   // clamp on the way in, the blinker never sees an oversized count
   assign wr_amount = (wr_i.amount > MAX_AMOUNT) ? MAX_AMOUNT : wr_i.amount;

   // channel match per slot, indexes past g_num_chan hit nothing
   always_ff @(posedge ClkRs_ix or negedge rst_n_i) begin
      if (!rst_n_i) begin
         amount_o <= '0;
         force_o <= '0;
      end else if (wr_stb_i) begin
         for (int i = 0; i < g_num_chan; i++) begin
            if (wr_i.chan == led_chan_t'(i)) begin
               amount_o[i] <= wr_amount;
               force_o[i] <= wr_i.force_on;
            end
         end
      end
   end

   // read mux, unknown channel reads as zero
   always_comb begin
      rd_data = '0;
      for (int i = 0; i < g_num_chan; i++) begin
         if (rd_chan_i == led_chan_t'(i)) begin
            rd_data.amount = amount_o[i];
            rd_data.force_on = force_o[i];
         end
      end
   end

   // read data, captured only on a request
   always_ff @(posedge ClkRs_ix) begin
      if (rd_stb_i)
         rd_o <= rd_data;
   end

   always_ff @(posedge ClkRs_ix or negedge rst_n_i) begin
      if (!rst_n_i)
         rd_valid_o <= 1'b0;
      else
         rd_valid_o <= rd_stb_i;
   end

endmodule

// File: led_frame_timer.sv
//------------------------------------------------------------
// frame timer, one tick per repetition frame
//------------------------------------------------------------
`timescale 1ns/100ps

module led_frame_timer #(
   parameter int g_total_period = 64
) (
   input  logic ClkRs_ix,
   input  logic rst_n_i,
   output logic frame_tick_o
);

   // counter only has to hold period - 1
   localparam int CNT_W = (g_total_period > 1) ? $clog2(g_total_period) : 1;
   localparam logic [CNT_W-1:0] RELOAD = CNT_W'(g_total_period - 1);

   logic [CNT_W-1:0] cnt_q;

   // down-counter, reload and tick share the same edge
   // so the first tick lands g_total_period cycles after reset
   always_ff @(posedge ClkRs_ix or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= RELOAD;
         frame_tick_o <= 1'b0;
      end else begin
         if (cnt_q == '0) begin
            cnt_q <= RELOAD;
            frame_tick_o <= 1'b1;
         end else begin
            cnt_q <= cnt_q - 1'b1;
            frame_tick_o <= 1'b0;
         end
      end
   end

endmodule

// File: led_status_pkg.sv
//------------------------------------------------------------
// field widths, host write and read-back structs
// blinker state encoding
//------------------------------------------------------------

package led_status_pkg;

   //------------------------------------------------------------
   // field widths
   //------------------------------------------------------------

   // blink count per channel and per frame
   localparam int AMOUNT_W = 8;
   // channel index, enough for eight channels
   localparam int CHAN_W = 3;

   //------------------------------------------------------------
   // scalar types
   //------------------------------------------------------------

   typedef logic [AMOUNT_W-1:0] led_amount_t;
   typedef logic [CHAN_W-1:0] led_chan_t;

   //------------------------------------------------------------
   // host side structs
   //------------------------------------------------------------

   // one host write, taken on the write strobe
   typedef struct packed {
      led_chan_t chan;
      led_amount_t amount;
      // holds the led on whatever the pattern
      logic force_on;
   } led_wr_t;

   // stored value of one channel as seen by the host
   typedef struct packed {
      led_amount_t amount;
      logic force_on;
   } led_rd_t;

   //------------------------------------------------------------
   // blinker FSM
   //------------------------------------------------------------

   // COUNTDOWN decides between another pulse and going dark
   typedef enum logic [1:0] {
      IDLE      = 2'd0,
      LED_ON    = 2'd1,
      LED_OFF   = 2'd2,
      COUNTDOWN = 2'd3
   } blink_state_e;

endpackage
